/* Makefile */
# blit engine testbench on Verilator

SIM := obj_dir/Vtb_groovy_blit

.PHONY: all run clean

all: run

$(SIM): vlog.f $(shell grep -v '^+' vlog.f) include/groovy_defs.svh
	verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_groovy_blit -f vlog.f -o Vtb_groovy_blit

run: $(SIM)
	$(SIM) | tee sim.log
	@! grep -q "RESULT: FAIL" sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_checker.sv */
// checks pixels against the seed rule, modeline and last_frame at each cmd_ack
// also checks the spacing of ce_pix pulses
`timescale 1ns/10ps
`default_nettype none

module tb_checker
	import groovy_pkg::*;
(
	input  wire             clk_sys, arst_n, cmd_ack, mem_req, ce_pix,
	input  wire             pix_valid, pix_ready,
	input  wire rgb_t       pix_rgb,
	input  wire frame_t     last_frame, exp_frame,
	input  wire h_len_t     h_active, v_active,
	input  wire porch_t     h_fp, h_sync, h_bp, v_fp, v_sync, v_bp,
	input  wire ce_div_t    ce_div,
	input  wire [31:0]      seed,        // pixel seed of current step
	input  wire [87:0]      exp_mode,    // expected modeline record, h_active lowest
	input  wire pix_count_t exp_count,
	output int              err_count, check_count, ce_checked
);

	int unsigned n_pix;     // pixels taken since last ack
	int          gap;       // cycles since last ce_pix
	int          ce_seen;   // pulses since divider expectation changed
	bit          ack_q, rst_done;
	ce_div_t     div_exp;

	// pixel n of a frame, odd multiplier keeps pixels distinct
	function automatic rgb_t seeded_pixel(input logic [31:0] s, input int unsigned n);
		return rgb_t'(s ^ (n * 32'h0001_0307));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, want);
		check_count++;
		if (got !== want) begin
			err_count++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	// record fields in packing order
	task automatic check_state;
		check_value("last_frame", 32'(last_frame), 32'(exp_frame));
		check_value("h_active", 32'(h_active), 32'(exp_mode[15:0]));
		check_value("h_fp", 32'(h_fp), 32'(exp_mode[23:16]));
		check_value("h_sync", 32'(h_sync), 32'(exp_mode[31:24]));
		check_value("h_bp", 32'(h_bp), 32'(exp_mode[39:32]));
		check_value("v_active", 32'(v_active), 32'(exp_mode[55:40]));
		check_value("v_fp", 32'(v_fp), 32'(exp_mode[63:56]));
		check_value("v_sync", 32'(v_sync), 32'(exp_mode[71:64]));
		check_value("v_bp", 32'(v_bp), 32'(exp_mode[79:72]));
		check_value("ce_div", 32'(ce_div), 32'(exp_mode[87:80]));
	endtask

	//////////////////// sampled on the rising edge, before the DUT updates
	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rst_done = 1'b0;
		end else begin
			if (!rst_done) begin   // first edge out of reset
				check_value("cmd_ack", 32'(cmd_ack), 0);
				check_value("mem_req", 32'(mem_req), 0);
				check_value("pix_valid", 32'(pix_valid), 0);
				check_state();
				div_exp  = exp_mode[87:80];
				ce_seen  = 0;
				gap      = 0;
				n_pix    = 0;
				rst_done = 1'b1;
			end
			if (pix_valid && pix_ready) begin   // one transfer
				check_value("pix_rgb", 32'(pix_rgb), 32'(seeded_pixel(seed, n_pix)));
				n_pix++;
			end
			if (cmd_ack && !ack_q) begin   // command done
				check_value("pixel count", n_pix, 32'(exp_count));
				check_state();
				n_pix   = 0;
				div_exp = exp_mode[87:80];
				ce_seen = 0;   // old period may still be running
			end
			ack_q = cmd_ack;
			if (ce_pix) begin
				if (ce_seen >= 2) begin
					check_value("ce_pix interval", gap, 32'(div_exp));
					ce_checked++;
				end
				ce_seen++;
				gap = 1;
			end else begin
				gap++;
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_groovy_blit.sv */
// blit engine testbench, clock, reset, memory model
// command table applied in a loop, sink with random stalls
`timescale 1ns/10ps
`default_nettype none

module tb_groovy_blit
	import groovy_pkg::*;
();

	localparam int LIMIT  = 2000;   // cycles allowed per wait
	localparam int NSTEPS = 6;
	// ce_div, vbp, vs, vfp, v, hbp, hs, hfp, h from the top down
	localparam logic [87:0] DEF_REC =
		{8'd16, 8'd16, 8'd3, 8'd2, 16'd240, 8'd41, 8'd24, 8'd10, 16'd256};
	localparam logic [87:0] MODE_A =
		{8'd6, 8'd20, 8'd5, 8'd4, 16'd224, 8'd48, 8'd32, 8'd16, 16'd320};
	localparam logic [87:0] MODE_B =
		{8'd11, 8'd33, 8'd6, 8'd1, 16'd480, 8'd60, 8'd44, 8'd20, 16'd640};

	typedef struct packed {
		cmd_op_t     op;
		logic [87:0] rec;     // modeline record, or header in low 48 bits
		logic [31:0] seed;
		logic [7:0]  drop;    // percent of cycles with pix_ready low
		pix_count_t  count;   // pixels expected
		frame_t      frame;   // last_frame after the command
	} step_t;

	step_t steps [NSTEPS] = '{
		'{op_switchres, MODE_A, 32'h0, 8'd0, 24'd0, 24'd0},
		'{op_blit, {40'd0, 24'd29, 24'd5}, 32'h00c0ffee, 8'd0, 24'd29, 24'd5},    // 3 chunks + 5
		'{op_blit, {40'd0, 24'd29, 24'd6}, 32'h00c0ffee, 8'd40, 24'd29, 24'd6},   // sink stalls
		'{op_blit, {40'd0, 24'd17, 24'd6}, 32'h00000bad, 8'd0, 24'd0, 24'd6},     // same frame
		'{op_blit, {40'd0, 24'd17, 24'd2}, 32'h00000bad, 8'd50, 24'd0, 24'd6},    // older frame
		'{op_switchres, MODE_B, 32'h0, 8'd0, 24'd0, 24'd6}
	};

	logic        clk_sys = 1'b0;   // no edge at time zero
	logic        arst_n, cmd_req, cmd_ack, mem_req, mem_valid, mem_ack;
	logic        pix_valid, pix_ready, ce_pix;
	cmd_op_t     cmd_op;
	mem_addr_t   mem_addr;
	burst_t      mem_burst;
	mem_word_t   mem_data;
	rgb_t        pix_rgb;
	frame_t      last_frame, exp_frame;
	h_len_t      h_active, v_active;
	porch_t      h_fp, h_sync, h_bp, v_fp, v_sync, v_bp;
	ce_div_t     ce_div;
	logic [31:0] seed;
	logic [87:0] exp_mode;
	pix_count_t  exp_count;
	int          err_count, check_count, ce_checked;
	int unsigned drop;
	mem_word_t   mem_words [512];

	groovy_blit_top uut (.*);
	tb_checker chk (.*);

	function automatic rgb_t seeded_pixel(input logic [31:0] s, input int unsigned n);
		return rgb_t'(s ^ (n * 32'h0001_0307));
	endfunction

	//////////////////// memory image for one step
	task automatic load_memory(input step_t st);
		rgb_t px;
		for (int a = 0; a < 512; a++)
			mem_words[a] = {32'(a) ^ 32'h5a5a_0000, ~32'(a)};   // address stamped filler
		if (st.op == op_blit) begin
			mem_words[0] = st.rec[63:0];          // header word
		end else begin
			mem_words[8] = st.rec[63:0];          // modeline record
			mem_words[9] = 64'(st.rec[87:64]);
		end
		for (int b = 0; b < 48 * 64; b++) begin   // packed 24 bit pixel stream
			px = seeded_pixel(st.seed, b / 24);
			mem_words[256 + b / 64][b % 64] = px[b % 24];
		end
	endtask

	task automatic finish_run(input bit timed_out);
		$display("checks %0d errors %0d", check_count, err_count);
		if (!timed_out && err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout while waiting for %s", what);
		finish_run(1'b1);
	endtask

	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		while (cmd_ack !== level) begin
			@(negedge clk_sys);
			t++;
			if (t > LIMIT)
				fail_timeout("cmd_ack");
		end
	endtask

	// one more ce_pix interval checked under the current divider
	task automatic wait_ce_check;
		int t;
		int start;
		t = 0;
		start = ce_checked;
		while (ce_checked == start) begin
			@(negedge clk_sys);
			t++;
			if (t > LIMIT)
				fail_timeout("a ce_pix interval");
		end
	endtask

	initial begin
		forever #4 clk_sys = ~clk_sys;   // 125 MHz
	end

	always @(negedge clk_sys)
		pix_ready = ($urandom_range(99) >= drop);

	//////////////////// memory model
	initial begin : memory_model
		int t;
		mem_valid = 1'b0;
		mem_ack   = 1'b0;
		mem_data  = '0;
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				for (int i = 0; i < int'(mem_burst); i++) begin
					repeat ($urandom_range(2)) @(negedge clk_sys);   // random read latency
					mem_valid = 1'b1;
					mem_data  = mem_words[9'(mem_addr) + 9'(i)];
					@(negedge clk_sys);
					mem_valid = 1'b0;
				end
				mem_ack = 1'b1;
				t = 0;
				while (mem_req) begin   // hold ack until req drops
					@(negedge clk_sys);
					t++;
					if (t > LIMIT)
						fail_timeout("mem_req to drop");
				end
				mem_ack = 1'b0;
			end
		end
	end

	//////////////////// stimulus
	initial begin : stimulus
		void'($urandom(6728));
		arst_n    = 1'b0;
		cmd_req   = 1'b0;
		cmd_op    = op_switchres;
		pix_ready = 1'b0;
		drop      = 0;
		seed      = '0;
		exp_mode  = DEF_REC;
		exp_count = '0;
		exp_frame = '0;
		repeat (2) @(negedge clk_sys);
		arst_n = 1'b1;
		wait_ce_check();   // default divider
		foreach (steps[i]) begin
			load_memory(steps[i]);
			seed      = steps[i].seed;
			drop      = 32'(steps[i].drop);
			exp_count = steps[i].count;
			exp_frame = steps[i].frame;
			if (steps[i].op == op_switchres)
				exp_mode = steps[i].rec;
			cmd_op  = steps[i].op;
			cmd_req = 1'b1;
			wait_ack(1'b1);
			cmd_req = 1'b0;   // four-phase release
			wait_ack(1'b0);
			wait_ce_check();
		end
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

/* hdl/blit_fsm.sv */
// command FSM for switchres and blit
// runs the cmd and memory handshakes, drains chunks to the pixel port
`timescale 1ns/10ps
`default_nettype none

module blit_fsm
	import groovy_pkg::*;
#(
	parameter int CHUNK_PIXELS = 8
) (
	input  wire            clk_sys,
	input  wire            arst_n,
	// host command
	input  wire            cmd_req,
	input  wire cmd_op_t   cmd_op,
	output logic           cmd_ack,
	// memory read port
	output logic           mem_req,
	output mem_addr_t      mem_addr,
	output burst_t         mem_burst,
	input  wire            mem_valid,
	input  wire mem_word_t mem_data,
	input  wire            mem_ack,
	// chunk buffer side
	output logic           word_we,
	output logic [7:0]     pix_idx,
	input  wire rgb_t      chunk_pix,
	// pixel sink
	output logic           pix_valid,
	output rgb_t           pix_rgb,
	input  wire            pix_ready,
	// status
	output logic           mode_load,
	output frame_t         last_frame
);

	localparam int         CHUNK_WORDS = CHUNK_PIXELS * 3 / 8;   // 24 bit pixels, 64 bit words
	localparam logic [7:0] LAST_IDX    = 8'(CHUNK_PIXELS - 1);

	blit_state_t state;
	frame_t      hdr_frame;   // frame number from header
	pix_count_t  pix_left;    // pixels still owed to the sink

	// buffer fills on every data word of a modeline or chunk burst
	assign word_we   = mem_valid && (state == st_mode_req || state == st_chunk_req);
	assign pix_valid = (state == st_pixel_out);
	assign pix_rgb   = chunk_pix;   // held while pix_idx is held

	always_ff @(posedge clk_sys) begin
		if (state == st_hdr_req && mem_valid)
			hdr_frame <= mem_data[23:0];
	end

	//////////////////// sequencer
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			cmd_ack    <= 1'b0;
			mem_req    <= 1'b0;
			mem_addr   <= '0;
			mem_burst  <= '0;
			mode_load  <= 1'b0;
			pix_idx    <= '0;
			pix_left   <= '0;
			last_frame <= '0;
		end else begin
			mode_load <= 1'b0;   // single cycle pulse
			case (state)
				st_idle: begin
					if (cmd_req && !mem_ack) begin   // previous burst fully closed
						mem_req <= 1'b1;
						if (cmd_op == op_switchres) begin
							mem_addr  <= MODELINE_ADDR;
							mem_burst <= MODELINE_WORDS;
							state     <= st_mode_req;
						end else begin
							mem_addr  <= HEADER_ADDR;
							mem_burst <= burst_t'(1);
							state     <= st_hdr_req;
						end
					end
				end
				st_mode_req: begin
					if (mem_ack) begin   // all words already in buffer
						mem_req   <= 1'b0;
						mode_load <= 1'b1;
						state     <= st_mode_load;
					end
				end
				st_mode_load: begin
					if (!mem_ack)
						state <= st_done;
				end
				st_hdr_req: begin
					if (mem_valid)
						pix_left <= mem_data[47:24];
					if (mem_ack) begin
						mem_req <= 1'b0;
						state   <= st_hdr_check;
					end
				end
				st_hdr_check: begin
					pix_idx <= '0;
					if (!mem_ack) begin
						if (hdr_frame <= last_frame) begin
							state <= st_done;   // stale frame, skip
						end else if (pix_left == '0) begin
							last_frame <= hdr_frame;
							state      <= st_done;
						end else begin
							mem_addr  <= PIXEL_BASE_ADDR;
							mem_burst <= burst_t'(CHUNK_WORDS);
							state     <= st_chunk_req;
						end
					end
				end
				st_chunk_req: begin
					if (!mem_req && !mem_ack) begin   // last ack gone, open next burst
						mem_req <= 1'b1;
					end else if (mem_req && mem_ack) begin
						mem_req <= 1'b0;
						state   <= st_pixel_out;
					end
				end
				st_pixel_out: begin
					if (pix_ready) begin
						pix_left <= pix_left - pix_count_t'(1);
						if (pix_left == pix_count_t'(1)) begin   // frame complete
							last_frame <= hdr_frame;
							state      <= st_done;
						end else if (pix_idx == LAST_IDX) begin   // chunk drained
							pix_idx  <= '0;
							mem_addr <= mem_addr + mem_addr_t'(CHUNK_WORDS);
							state    <= st_chunk_req;
						end else begin
							pix_idx <= pix_idx + 8'd1;
						end
					end
				end
				st_done: begin
					cmd_ack <= 1'b1;
					if (cmd_ack && !cmd_req) begin   // host released req
						cmd_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/chunk_buffer.sv */
// chunk buffer, shift register of memory words
// pixel mux and modeline record slice
`timescale 1ns/10ps
`default_nettype none

module chunk_buffer
	import groovy_pkg::*;
#(
	parameter int CHUNK_PIXELS = 8
) (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire                      word_we,
	input  wire mem_word_t           mem_data,
	input  wire [7:0]                pix_idx,
	output rgb_t                     chunk_pix,
	output logic [MODELINE_BITS-1:0] chunk_bits
);

	localparam int CHUNK_WORDS = CHUNK_PIXELS * 3 / 8;
	localparam int CHUNK_BITS  = CHUNK_WORDS * 64;
	// a short modeline burst ends up in the top words
	localparam int MODE_LSB    = CHUNK_BITS - int'(MODELINE_WORDS) * 64;

	logic [CHUNK_BITS-1:0] chunk_q;   // word 0 lowest once a full burst is in

	//////////////////// fill
	// new word enters at the top, older words move down one slot
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			chunk_q <= '0;   // start empty
		end else if (word_we) begin
			chunk_q <= {mem_data, chunk_q[CHUNK_BITS-1:64]};
		end
	end

	//////////////////// read
	// pixel k at bits 24k and up, low pixel of a word first
	assign chunk_pix = chunk_q[pix_idx*24 +: 24];

	// modeline record, 88 bits from start of its burst
	assign chunk_bits = chunk_q[MODE_LSB +: MODELINE_BITS];

endmodule

`default_nettype wire

/* hdl/groovy_blit_top.sv */
// blit engine top level
// command FSM, chunk buffer, modeline registers, pixel enable
`timescale 1ns/10ps
`default_nettype none

module groovy_blit_top
	import groovy_pkg::*;
#(
	parameter int CHUNK_PIXELS = 8   // multiple of 8, whole words per chunk
) (
	input  wire            clk_sys,
	input  wire            arst_n,
	input  wire            cmd_req,
	input  wire cmd_op_t   cmd_op,
	output logic           cmd_ack,
	output logic           mem_req,
	output mem_addr_t      mem_addr,
	output burst_t         mem_burst,
	input  wire            mem_valid,
	input  wire mem_word_t mem_data,
	input  wire            mem_ack,
	output logic           pix_valid,
	output rgb_t           pix_rgb,
	input  wire            pix_ready,
	output logic           ce_pix,
	output frame_t         last_frame,
	output h_len_t         h_active,
	output h_len_t         v_active,
	output porch_t         h_fp,
	output porch_t         h_sync,
	output porch_t         h_bp,
	output porch_t         v_fp,
	output porch_t         v_sync,
	output porch_t         v_bp,
	output ce_div_t        ce_div
);

	logic                     word_we;      // one per burst word
	logic [7:0]               pix_idx;      // pixel within chunk
	rgb_t                     chunk_pix;
	logic [MODELINE_BITS-1:0] chunk_bits;   // modeline record
	logic                     mode_load;

	blit_fsm #(.CHUNK_PIXELS(CHUNK_PIXELS)) u_fsm (.*);

	chunk_buffer #(.CHUNK_PIXELS(CHUNK_PIXELS)) u_buf (
		.clk_sys, .arst_n, .word_we, .mem_data, .pix_idx, .chunk_pix, .chunk_bits
	);

	modeline_regs u_mode (
		.clk_sys, .arst_n, .mode_load, .chunk_bits,
		.h_active, .h_fp, .h_sync, .h_bp,
		.v_active, .v_fp, .v_sync, .v_bp, .ce_div
	);

	pixel_ce_div u_ce (.clk_sys, .arst_n, .ce_div, .ce_pix);

endmodule

`default_nettype wire

/* hdl/groovy_pkg.sv */
// shared width typedefs, FSM state and command enums
// memory map and default modeline constants
`default_nettype none

package groovy_pkg;

	//////////////////// widths
	typedef logic [63:0] mem_word_t;    // one memory data word
	typedef logic [27:0] mem_addr_t;    // word address
	typedef logic [7:0]  burst_t;       // words per burst
	typedef logic [23:0] rgb_t;         // r, g, b bytes
	typedef logic [23:0] frame_t;       // frame number
	typedef logic [23:0] pix_count_t;   // pixels in a frame
	typedef logic [15:0] h_len_t;       // active width / height
	typedef logic [7:0]  porch_t;       // porch and sync lengths
	typedef logic [7:0]  ce_div_t;      // pixel clock divider

	//////////////////// enums
	typedef enum logic [2:0] {
		st_idle,        // wait for host command
		st_mode_req,    // modeline burst in flight
		st_mode_load,   // apply record, wait mem ack low
		st_hdr_req,     // header burst in flight
		st_hdr_check,   // compare frame with last one done
		st_chunk_req,   // pixel chunk burst
		st_pixel_out,   // drain chunk to sink
		st_done         // cmd ack handshake
	} blit_state_t;

	typedef enum logic {
		op_switchres,
		op_blit
	} cmd_op_t;

	// constants use the typedefs above
	`include "groovy_defs.svh"

endpackage

`default_nettype wire

/* hdl/modeline_regs.sv */
// active modeline registers
// record unpack on load, defaults after reset
`timescale 1ns/10ps
`default_nettype none

module modeline_regs
	import groovy_pkg::*;
(
	input  wire                     clk_sys,
	input  wire                     arst_n,
	input  wire                     mode_load,
	input  wire [MODELINE_BITS-1:0] chunk_bits,
	output h_len_t                  h_active,
	output porch_t                  h_fp,
	output porch_t                  h_sync,
	output porch_t                  h_bp,
	output h_len_t                  v_active,
	output porch_t                  v_fp,
	output porch_t                  v_sync,
	output porch_t                  v_bp,
	output ce_div_t                 ce_div
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin   // power-up mode
			h_active <= DEF_H;
			h_fp     <= DEF_HFP;
			h_sync   <= DEF_HS;
			h_bp     <= DEF_HBP;
			v_active <= DEF_V;
			v_fp     <= DEF_VFP;
			v_sync   <= DEF_VS;
			v_bp     <= DEF_VBP;
			ce_div   <= DEF_CE_DIV;
		end else if (mode_load) begin
			// record layout, low bits first
			h_active <= chunk_bits[0  +: 16];
			h_fp     <= chunk_bits[16 +: 8];
			h_sync   <= chunk_bits[24 +: 8];
			h_bp     <= chunk_bits[32 +: 8];
			v_active <= chunk_bits[40 +: 16];
			v_fp     <= chunk_bits[56 +: 8];
			v_sync   <= chunk_bits[64 +: 8];
			v_bp     <= chunk_bits[72 +: 8];
			ce_div   <= chunk_bits[80 +: 8];   // pixel clock divider
		end
	end

endmodule

`default_nettype wire

/* hdl/pixel_ce_div.sv */
// pixel clock enable from system clock
`timescale 1ns/10ps
`default_nettype none

module pixel_ce_div
	import groovy_pkg::*;
(
	input  wire          clk_sys,
	input  wire          arst_n,
	input  wire ce_div_t ce_div,
	output logic         ce_pix
);

	ce_div_t cnt;     // position in pixel period
	ce_div_t div_q;   // divider in use, swapped at wrap only

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt    <= '0;
			div_q  <= DEF_CE_DIV;
			ce_pix <= 1'b0;
		end else begin
			ce_pix <= (cnt == '0);   // one pulse per period
			if (cnt == div_q - 8'd1) begin
				cnt   <= '0;
				div_q <= ce_div;   // new divider from next period on
			end else begin
				cnt <= cnt + 8'd1;
			end
		end
	end
endmodule

`default_nettype wire

/* include/groovy_defs.svh */
// memory map constants
// power-up modeline, 256x240 at divider 16
`ifndef GROOVY_DEFS_SVH
`define GROOVY_DEFS_SVH

//////////////////// memory map
localparam mem_addr_t HEADER_ADDR     = 28'd0;    // frame header word
localparam mem_addr_t MODELINE_ADDR   = 28'd8;    // modeline record
localparam mem_addr_t PIXEL_BASE_ADDR = 28'd256;  // first pixel word
localparam burst_t    MODELINE_WORDS  = 8'd2;     // record burst length
localparam int        MODELINE_BITS   = 88;       // packed record width

//////////////////// default modeline
localparam h_len_t  DEF_H      = 16'd256;
localparam porch_t  DEF_HFP    = 8'd10;
localparam porch_t  DEF_HS     = 8'd24;
localparam porch_t  DEF_HBP    = 8'd41;
localparam h_len_t  DEF_V      = 16'd240;
localparam porch_t  DEF_VFP    = 8'd2;
localparam porch_t  DEF_VS     = 8'd3;
localparam porch_t  DEF_VBP    = 8'd16;
localparam ce_div_t DEF_CE_DIV = 8'd16;   // 1 pixel per 16 system clocks
`endif

/* vlog.f */
+incdir+include
hdl/groovy_pkg.sv
hdl/blit_fsm.sv
hdl/chunk_buffer.sv
hdl/modeline_regs.sv
hdl/pixel_ce_div.sv
hdl/groovy_blit_top.sv
dv/tb_checker.sv
dv/tb_groovy_blit.sv
